//--- cnn_accel_config.svh
`ifndef CNN_ACCEL_CONFIG_SVH
`define CNN_ACCEL_CONFIG_SVH

//////////////////////////////
// Array geometry
//////////////////////////////
`define CNN_LANES 4
`define CNN_DATA_W 8
// Accumulators wrap on overflow
`define CNN_PSUM_W 16

// Weight and input-feature buffers
`define CNN_BUF_DEPTH 64
`define CNN_ADDR_W 6

// One lane value per result address
`define CNN_RES_ADDR_W 8

//////////////////////////////
// Array to pool stage link
//////////////////////////////
// Pool FIFO depth, also the credit count after reset
`define CNN_CREDITS 4

`endif

//--- cnn_data_pkg.sv
`include "cnn_accel_config.svh"

package cnn_data_pkg;

    // One operand byte
    typedef logic signed [`CNN_DATA_W-1:0] data_t;

    // One accumulator value
    typedef logic signed [`CNN_PSUM_W-1:0] psum_t;

    // Weights of all lanes for one tap
    typedef data_t [`CNN_LANES-1:0] weight_row_t;

    // One value per lane
    typedef psum_t [`CNN_LANES-1:0] psum_row_t;

    // Beat from the MAC array to the pool stage
    typedef struct packed {
        psum_row_t psum;
        logic      last;    // final output of the layer
    } psum_beat_t;

endpackage

//--- cnn_ctrl_pkg.sv
`include "cnn_accel_config.svh"

package cnn_ctrl_pkg;

    // Layer command, same coding as the host start field
    typedef enum logic [1:0] {
        CMD_IDLE = 2'd0,
        CMD_CONV = 2'd1,
        CMD_FC   = 2'd2
    } cmd_e;

    typedef enum logic [1:0] {
        ST_IDLE        = 2'd0,
        ST_RUN         = 2'd1,
        ST_WAIT_CREDIT = 2'd2,
        ST_DRAIN       = 2'd3
    } mac_state_e;

    // Tap and output counts run up to the buffer depth
    typedef logic [`CNN_ADDR_W:0] count_t;

    typedef struct packed {
        cmd_e   cmd;
        count_t taps;   // K
        count_t outs;   // N, even for convolution
    } layer_cfg_t;

endpackage

//--- operand_bram.sv
`timescale 1ns/1ns
`include "cnn_accel_config.svh"

module operand_bram (
    input  logic                        clk,
    input  logic                        wgt_we_i,
    input  logic [`CNN_ADDR_W-1:0]      wgt_addr_i,
    input  cnn_data_pkg::weight_row_t   wgt_row_i,
    input  logic                        ifm_we_i,
    input  logic [`CNN_ADDR_W-1:0]      ifm_addr_i,
    input  cnn_data_pkg::data_t         ifm_data_i,
    input  logic                        rd_en_i,
    input  logic [`CNN_ADDR_W-1:0]      wgt_raddr_i,
    input  logic [`CNN_ADDR_W-1:0]      ifm_raddr_i,
    output cnn_data_pkg::weight_row_t   wgt_row_o,
    output cnn_data_pkg::data_t         ifm_data_o
);

    import cnn_data_pkg::*;

    // One weight row per tap, one byte per feature position
    weight_row_t wgt_mem [`CNN_BUF_DEPTH];
    data_t       ifm_mem [`CNN_BUF_DEPTH];

    // Host write ports
    always_ff @(posedge clk) begin
        if (wgt_we_i) begin
            wgt_mem[wgt_addr_i] <= wgt_row_i;
        end
        if (ifm_we_i) begin
            ifm_mem[ifm_addr_i] <= ifm_data_i;
        end
    end

    // Array read port, data valid the cycle after rd_en_i
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            wgt_row_o  <= wgt_mem[wgt_raddr_i];
            ifm_data_o <= ifm_mem[ifm_raddr_i];
        end
    end

endmodule

//--- mac_array.sv
`timescale 1ns/1ns
`include "cnn_accel_config.svh"

module mac_array (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        start_i,
    input  cnn_ctrl_pkg::layer_cfg_t    cfg_i,
    output logic                        rd_en_o,
    output logic [`CNN_ADDR_W-1:0]      wgt_raddr_o,
    output logic [`CNN_ADDR_W-1:0]      ifm_raddr_o,
    input  cnn_data_pkg::weight_row_t   wgt_row_i,
    input  cnn_data_pkg::data_t         ifm_data_i,
    output logic                        psum_valid_o,
    output cnn_data_pkg::psum_beat_t    psum_beat_o,
    input  logic                        credit_ret_i
);

    import cnn_data_pkg::*;
    import cnn_ctrl_pkg::*;

    localparam int CRED_W = $clog2(`CNN_CREDITS + 1);

    mac_state_e         state_q;
    count_t             taps_q;
    count_t             outs_q;
    count_t             tap_q;
    count_t             out_q;
    logic               rd_vld_q;
    logic               rd_first_q;
    psum_row_t          acc_q;
    psum_row_t          mac_sum;
    logic [CRED_W-1:0]  credit_q;
    logic               emit;
    logic               last_out;

    assign rd_en_o     = (state_q == ST_RUN);
    assign wgt_raddr_o = tap_q[`CNN_ADDR_W-1:0];
    // Feature window slides by one position per output
    assign ifm_raddr_o = out_q[`CNN_ADDR_W-1:0] + tap_q[`CNN_ADDR_W-1:0];
    assign last_out    = (out_q == outs_q - 1'b1);

    // Finished output leaves once a credit is free
    assign emit = ((state_q == ST_DRAIN) || (state_q == ST_WAIT_CREDIT))
                  && (credit_q != '0);

    // Lane MACs on the data read in the previous cycle
    always_comb begin
        for (int l = 0; l < `CNN_LANES; l++) begin
            mac_sum[l] = (rd_first_q ? psum_t'(0) : acc_q[l])
                       + psum_t'(signed'(wgt_row_i[l])) * psum_t'(signed'(ifm_data_i));
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= ST_IDLE;
            taps_q       <= '0;
            outs_q       <= '0;
            tap_q        <= '0;
            out_q        <= '0;
            rd_vld_q     <= 1'b0;
            rd_first_q   <= 1'b0;
            psum_valid_o <= 1'b0;
        end else begin
            rd_vld_q     <= rd_en_o;
            rd_first_q   <= (tap_q == '0);
            psum_valid_o <= emit;
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        taps_q  <= cfg_i.taps;
                        // FC layers produce a single output per lane
                        outs_q  <= (cfg_i.cmd == CMD_FC) ? count_t'(1) : cfg_i.outs;
                        tap_q   <= '0;
                        out_q   <= '0;
                        state_q <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (tap_q == taps_q - 1'b1) begin
                        tap_q   <= '0;
                        state_q <= ST_DRAIN;
                    end else begin
                        tap_q <= tap_q + 1'b1;
                    end
                end
                default: begin
                    if (emit) begin
                        out_q   <= out_q + 1'b1;
                        state_q <= last_out ? ST_IDLE : ST_RUN;
                    end else begin
                        state_q <= ST_WAIT_CREDIT;
                    end
                end
            endcase
        end
    end

    // Credit spent while a beat is on the link
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_q <= CRED_W'(`CNN_CREDITS);
        end else begin
            credit_q <= credit_q - CRED_W'(psum_valid_o) + CRED_W'(credit_ret_i);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_vld_q) begin
            acc_q <= mac_sum;
        end
        if (emit) begin
            // In WAIT_CREDIT the final sum already sits in acc_q
            psum_beat_o.psum <= (state_q == ST_DRAIN) ? mac_sum : acc_q;
            psum_beat_o.last <= last_out;
        end
    end

    // Pool stage never returns more credits than it was given
    assert property (@(posedge clk) disable iff (!arst_n_i)
        credit_q <= CRED_W'(`CNN_CREDITS));

    // A beat on the link is always covered by a credit
    assert property (@(posedge clk) disable iff (!arst_n_i)
        psum_valid_o |-> (credit_q != '0));

endmodule

//--- acc_pool.sv
`timescale 1ns/1ns
`include "cnn_accel_config.svh"

module acc_pool (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  cnn_ctrl_pkg::cmd_e          cmd_i,
    input  logic                        psum_valid_i,
    input  cnn_data_pkg::psum_beat_t    psum_beat_i,
    output logic                        credit_ret_o,
    input  logic                        res_re_i,
    input  logic [`CNN_RES_ADDR_W-1:0]  res_addr_i,
    output cnn_data_pkg::psum_t         res_data_o,
    output logic                        done_o
);

    import cnn_data_pkg::*;
    import cnn_ctrl_pkg::*;

    localparam int PTR_W  = $clog2(`CNN_CREDITS);
    localparam int LANE_W = $clog2(`CNN_LANES);
    localparam int ROW_W  = `CNN_RES_ADDR_W - LANE_W;

    //////////////////////////////
    // Input FIFO
    //////////////////////////////
    psum_beat_t         fifo_mem [`CNN_CREDITS];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [PTR_W:0]     count_q;
    logic               pop;
    psum_beat_t         head;

    psum_row_t          relu_row;
    psum_row_t          hold_q;
    psum_row_t          wr_row;
    logic               have_first_q;
    logic [ROW_W-1:0]   row_q;
    logic               wr_en;

    // Result rows hold all lanes of one pooled output
    psum_row_t          res_mem [2**ROW_W];
    psum_row_t          rd_row_q;
    logic [LANE_W-1:0]  rd_lane_q;

    assign pop  = (count_q != '0);
    assign head = fifo_mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (psum_valid_i) begin
            fifo_mem[wr_ptr_q] <= psum_beat_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            count_q      <= '0;
            credit_ret_o <= 1'b0;
        end else begin
            wr_ptr_q     <= wr_ptr_q + PTR_W'(psum_valid_i);
            rd_ptr_q     <= rd_ptr_q + PTR_W'(pop);
            count_q      <= count_q + (PTR_W+1)'(psum_valid_i) - (PTR_W+1)'(pop);
            credit_ret_o <= pop;
        end
    end

    //////////////////////////////
    // ReLU and 2:1 max pooling
    //////////////////////////////
    always_comb begin
        for (int l = 0; l < `CNN_LANES; l++) begin
            relu_row[l] = head.psum[l][`CNN_PSUM_W-1] ? psum_t'(0) : head.psum[l];
            if (cmd_i == CMD_FC) begin
                wr_row[l] = head.psum[l];
            end else begin
                // both sides are non-negative here
                wr_row[l] = (hold_q[l] > relu_row[l]) ? hold_q[l] : relu_row[l];
            end
        end
    end

    assign wr_en = pop && ((cmd_i == CMD_FC) || have_first_q);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            have_first_q <= 1'b0;
            row_q        <= '0;
            done_o       <= 1'b0;
        end else begin
            done_o <= wr_en && head.last;
            if (pop && (cmd_i == CMD_CONV)) begin
                have_first_q <= !have_first_q;
            end
            if (wr_en) begin
                row_q <= head.last ? '0 : row_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop && !have_first_q) begin
            hold_q <= relu_row;
        end
        if (wr_en) begin
            res_mem[row_q] <= wr_row;
        end
    end

    // Host readback, one cycle latency
    always_ff @(posedge clk) begin
        if (res_re_i) begin
            rd_row_q  <= res_mem[res_addr_i[`CNN_RES_ADDR_W-1:LANE_W]];
            rd_lane_q <= res_addr_i[LANE_W-1:0];
        end
    end

    assign res_data_o = rd_row_q[rd_lane_q];

    // Credit loop in the MAC array keeps the FIFO from overflowing
    assert property (@(posedge clk) disable iff (!arst_n_i)
        psum_valid_i |-> (count_q < (PTR_W+1)'(`CNN_CREDITS)));

endmodule

//--- accel_top.sv
`timescale 1ns/1ns
`include "cnn_accel_config.svh"

module accel_top (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        start_i,
    input  cnn_ctrl_pkg::layer_cfg_t    cfg_i,
    input  logic                        wgt_we_i,
    input  logic [`CNN_ADDR_W-1:0]      wgt_addr_i,
    input  cnn_data_pkg::weight_row_t   wgt_row_i,
    input  logic                        ifm_we_i,
    input  logic [`CNN_ADDR_W-1:0]      ifm_addr_i,
    input  cnn_data_pkg::data_t         ifm_data_i,
    input  logic                        res_re_i,
    input  logic [`CNN_RES_ADDR_W-1:0]  res_addr_i,
    output cnn_data_pkg::psum_t         res_data_o,
    output logic                        busy_o,
    output logic                        done_o
);

    import cnn_data_pkg::*;
    import cnn_ctrl_pkg::*;

    layer_cfg_t                 cfg_q;
    logic                       start_q;
    logic                       busy_q;
    logic                       accept;
    logic                       rd_en;
    logic [`CNN_ADDR_W-1:0]     wgt_raddr;
    logic [`CNN_ADDR_W-1:0]     ifm_raddr;
    weight_row_t                wgt_row;
    data_t                      ifm_data;
    logic                       psum_valid;
    psum_beat_t                 psum_beat;
    logic                       credit_ret;

    //////////////////////////////
    // Command latch
    //////////////////////////////
    assign accept = start_i && !busy_o && (cfg_i.cmd != CMD_IDLE);
    assign busy_o = busy_q && !done_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cfg_q   <= '0;
            start_q <= 1'b0;
            busy_q  <= 1'b0;
        end else begin
            start_q <= accept;
            if (accept) begin
                cfg_q  <= cfg_i;
                busy_q <= 1'b1;
            end else if (done_o) begin
                busy_q <= 1'b0;
            end
        end
    end

    operand_bram u_operand_bram (
        .clk         (clk),
        .wgt_we_i    (wgt_we_i),
        .wgt_addr_i  (wgt_addr_i),
        .wgt_row_i   (wgt_row_i),
        .ifm_we_i    (ifm_we_i),
        .ifm_addr_i  (ifm_addr_i),
        .ifm_data_i  (ifm_data_i),
        .rd_en_i     (rd_en),
        .wgt_raddr_i (wgt_raddr),
        .ifm_raddr_i (ifm_raddr),
        .wgt_row_o   (wgt_row),
        .ifm_data_o  (ifm_data)
    );

    mac_array u_mac_array (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .start_i      (start_q),
        .cfg_i        (cfg_q),
        .rd_en_o      (rd_en),
        .wgt_raddr_o  (wgt_raddr),
        .ifm_raddr_o  (ifm_raddr),
        .wgt_row_i    (wgt_row),
        .ifm_data_i   (ifm_data),
        .psum_valid_o (psum_valid),
        .psum_beat_o  (psum_beat),
        .credit_ret_i (credit_ret)
    );

    acc_pool u_acc_pool (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .cmd_i        (cfg_q.cmd),
        .psum_valid_i (psum_valid),
        .psum_beat_i  (psum_beat),
        .credit_ret_o (credit_ret),
        .res_re_i     (res_re_i),
        .res_addr_i   (res_addr_i),
        .res_data_o   (res_data_o),
        .done_o       (done_o)
    );

endmodule

//--- tb_accel_top.sv
`timescale 1ns/1ns
`include "cnn_accel_config.svh"

module tb_accel_top;

    import cnn_data_pkg::*;
    import cnn_ctrl_pkg::*;

    localparam int ADDR_W  = `CNN_ADDR_W;
    localparam int RES_W   = `CNN_RES_ADDR_W;
    localparam int TIMEOUT = 2000;

    logic                   clk;
    logic                   arst_n_i;
    logic                   start_i;
    layer_cfg_t             cfg_i;
    logic                   wgt_we_i;
    logic [ADDR_W-1:0]      wgt_addr_i;
    weight_row_t            wgt_row_i;
    logic                   ifm_we_i;
    logic [ADDR_W-1:0]      ifm_addr_i;
    data_t                  ifm_data_i;
    logic                   res_re_i;
    logic [RES_W-1:0]       res_addr_i;
    psum_t                  res_data_o;
    logic                   busy_o;
    logic                   done_o;

    // Host-side copies of the buffer contents
    weight_row_t            wgt_sh [`CNN_BUF_DEPTH];
    data_t                  ifm_sh [`CNN_BUF_DEPTH];
    int                     errors;
    int                     checks;
    int                     beats;

    accel_top dut0 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .start_i    (start_i),
        .cfg_i      (cfg_i),
        .wgt_we_i   (wgt_we_i),
        .wgt_addr_i (wgt_addr_i),
        .wgt_row_i  (wgt_row_i),
        .ifm_we_i   (ifm_we_i),
        .ifm_addr_i (ifm_addr_i),
        .ifm_data_i (ifm_data_i),
        .res_re_i   (res_re_i),
        .res_addr_i (res_addr_i),
        .res_data_o (res_data_o),
        .busy_o     (busy_o),
        .done_o     (done_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Beats seen on the array to pool link
    always @(negedge clk) begin
        if (dut0.psum_valid) begin
            beats++;
        end
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic psum_t out_model(input int o, input int l, input int k);
        int sum;
        sum = 0;
        for (int t = 0; t < k; t++) begin
            sum += $signed(ifm_sh[o + t]) * $signed(wgt_sh[t][l]);
        end
        return psum_t'(sum);
    endfunction

    function automatic psum_t pool_model(input int p, input int l, input int k);
        psum_t a;
        psum_t b;
        a = out_model(2 * p, l, k);
        b = out_model(2 * p + 1, l, k);
        if (a < 0) begin
            a = 0;
        end
        if (b < 0) begin
            b = 0;
        end
        return (a > b) ? a : b;
    endfunction

    //////////////////////////////
    // Host tasks
    //////////////////////////////
    task automatic check_value(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic write_buffers();
        for (int i = 0; i < `CNN_BUF_DEPTH; i++) begin
            @(negedge clk);
            wgt_we_i   = 1'b1;
            wgt_addr_i = ADDR_W'(i);
            wgt_row_i  = wgt_sh[i];
            ifm_we_i   = 1'b1;
            ifm_addr_i = ADDR_W'(i);
            ifm_data_i = ifm_sh[i];
        end
        @(negedge clk);
        wgt_we_i = 1'b0;
        ifm_we_i = 1'b0;
    endtask

    task automatic start_layer(input cmd_e cmd, input int k, input int n);
        @(negedge clk);
        cfg_i.cmd  = cmd;
        cfg_i.taps = count_t'(k);
        cfg_i.outs = count_t'(n);
        start_i    = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
    endtask

    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        while (!done_o && cycles < TIMEOUT) begin
            check_value({name, " busy"}, 1, busy_o);
            @(negedge clk);
            cycles++;
        end
        if (done_o) begin
            check_value({name, " busy at done"}, 0, busy_o);
        end else begin
            errors++;
            $display("Timeout in %s: done_o did not pulse within %0d cycles", name, TIMEOUT);
        end
    endtask

    task automatic read_result(input int addr, output psum_t val);
        @(negedge clk);
        res_re_i   = 1'b1;
        res_addr_i = RES_W'(addr);
        @(negedge clk);
        res_re_i = 1'b0;
        val      = res_data_o;
    endtask

    // zero_lane names a lane that must read zero, -1 for none
    task automatic check_conv(input string name, input int k, input int n, input int zero_lane);
        psum_t got;
        for (int p = 0; p < n / 2; p++) begin
            for (int l = 0; l < `CNN_LANES; l++) begin
                read_result(p * `CNN_LANES + l, got);
                check_value(name, (l == zero_lane) ? 0 : pool_model(p, l, k), got);
            end
        end
    endtask

    task automatic fill_small();
        for (int i = 0; i < `CNN_BUF_DEPTH; i++) begin
            ifm_sh[i] = data_t'(i % 7 + 1);
            for (int l = 0; l < `CNN_LANES; l++) begin
                wgt_sh[i][l] = data_t'((i + l) % 5 + 1);
            end
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic test_conv_pool();
        fill_small();
        write_buffers();
        start_layer(CMD_CONV, 3, 8);
        wait_done("conv_pool");
        check_conv("conv_pool", 3, 8, -1);
    endtask

    task automatic test_relu();
        fill_small();
        for (int t = 0; t < `CNN_BUF_DEPTH; t++) begin
            wgt_sh[t][2] = data_t'(-3 * (t % 4 + 1));
        end
        write_buffers();
        start_layer(CMD_CONV, 3, 8);
        wait_done("relu");
        check_conv("relu", 3, 8, 2);
    endtask

    task automatic test_fc();
        psum_t got;
        for (int i = 0; i < `CNN_BUF_DEPTH; i++) begin
            ifm_sh[i]    = data_t'(127 - i);
            wgt_sh[i][0] = data_t'(127);
            wgt_sh[i][1] = data_t'(-128);
            wgt_sh[i][2] = data_t'(i - 32);
            wgt_sh[i][3] = data_t'($urandom());
        end
        write_buffers();
        start_layer(CMD_FC, 64, 1);
        wait_done("fc");
        for (int l = 0; l < `CNN_LANES; l++) begin
            read_result(l, got);
            check_value("fc", out_model(0, l, 64), got);
        end
    endtask

    task automatic test_busy_ignore();
        fill_small();
        for (int t = 0; t < `CNN_BUF_DEPTH; t++) begin
            wgt_sh[t][3] = data_t'(2 - t);
        end
        write_buffers();
        start_layer(CMD_CONV, 3, 8);
        check_value("busy_ignore rise", 1, busy_o);
        // Second command while busy, must have no effect
        cfg_i.cmd  = CMD_FC;
        cfg_i.taps = count_t'(64);
        cfg_i.outs = count_t'(1);
        start_i    = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        wait_done("busy_ignore");
        @(negedge clk);
        check_value("busy_ignore idle", 0, busy_o);
        check_value("busy_ignore done pulse", 0, done_o);
        check_conv("busy_ignore", 3, 8, -1);
    endtask

    task automatic test_backpressure();
        int first;
        for (int i = 0; i < `CNN_BUF_DEPTH; i++) begin
            ifm_sh[i] = data_t'($urandom());
            for (int l = 0; l < `CNN_LANES; l++) begin
                wgt_sh[i][l] = data_t'($urandom());
            end
        end
        write_buffers();
        first = beats;
        start_layer(CMD_CONV, 1, 64);
        wait_done("backpressure");
        check_value("backpressure beats", 64, beats - first);
        check_conv("backpressure", 1, 64, -1);
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        beats      = 0;
        arst_n_i   = 1'b0;
        start_i    = 1'b0;
        cfg_i      = '0;
        wgt_we_i   = 1'b0;
        wgt_addr_i = '0;
        wgt_row_i  = '0;
        ifm_we_i   = 1'b0;
        ifm_addr_i = '0;
        ifm_data_i = '0;
        res_re_i   = 1'b0;
        res_addr_i = '0;
        void'($urandom(32'hcefef2c5));
        repeat (3) @(negedge clk);
        arst_n_i = 1'b1;
        check_value("reset busy", 0, busy_o);
        check_value("reset done", 0, done_o);
        test_conv_pool();
        test_relu();
        test_fc();
        test_busy_ignore();
        test_backpressure();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- cnn_accel.f
+incdir+.
cnn_data_pkg.sv
cnn_ctrl_pkg.sv
operand_bram.sv
mac_array.sv
acc_pool.sv
accel_top.sv
tb_accel_top.sv

//--- Bender.yml
package:
  name: cnn_accel

export_include_dirs:
  - .

sources:
  - cnn_data_pkg.sv
  - cnn_ctrl_pkg.sv
  - operand_bram.sv
  - mac_array.sv
  - acc_pool.sv
  - accel_top.sv
  - target: test
    files:
      - tb_accel_top.sv
